//--- verilog.f
rv_inst_pkg.sv
bpu_cfg_pkg.sv
branch_decode.sv
bimodal_table.sv
branch_target_buffer.sv
return_stack.sv
next_pc_select.sv
bpu_top.sv
tb_bpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_bpu -f verilog.f -o sim_bpu > build.log 2>&1 \
    && ./obj_dir/sim_bpu > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; cat sim.log; exit 1; }

//--- tb_bpu.sv
module tb_bpu
    import rv_inst_pkg::*, bpu_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        call_push;
        xlen_t       ret_addr;
        logic        upd_valid;
        bpu_update_t upd;
        xlen_t       fetch_pc;
        inst_t       fetch_inst;
        bpu_pred_t   exp;
    } row_t;

    localparam inst_t I_NOP  = 32'h0000_0013;   // addi x0, x0, 0
    localparam inst_t I_BEQ  = 32'h0000_0863;   // beq x0, x0, +16
    localparam inst_t I_JAL  = 32'h1000_00ef;   // jal ra, +256
    localparam inst_t I_RET  = 32'h0000_8067;   // jalr x0, 0(ra)
    localparam inst_t I_JALR = 32'h0002_80e7;   // jalr ra, 0(t0), not a return
    localparam xlen_t JAL_OFF = 32'd256;

    localparam xlen_t BR_PC     = 32'h0000_1040;
    localparam xlen_t BR_TGT    = 32'h0000_2000;
    localparam xlen_t JAL_PC    = 32'h0000_3080;
    localparam xlen_t JAL_TGT   = 32'h0000_5000;   // differs from pc+offset
    localparam xlen_t JAL_ALIAS = 32'h0000_3480;   // same btb index, other tag
    localparam xlen_t RET_PC    = 32'h0000_4100;
    localparam xlen_t JALR_PC   = 32'h0000_6200;
    localparam xlen_t RA_A      = 32'h0000_0a04;
    localparam xlen_t RA_B      = 32'h0000_0b08;
    localparam xlen_t RA_C      = 32'h0000_0c0c;
    localparam bpu_update_t NO_UPD = '0;

    logic        clk;
    logic        rst;
    xlen_t       fetch_pc;
    inst_t       fetch_inst;
    logic        call_push;
    xlen_t       ret_addr;
    logic        upd_valid;
    bpu_update_t upd;
    bpu_pred_t   pred;

    row_t        rows[$];
    string       names[$];
    xlen_t       lcg_state = 32'd29;
    int          cycle_cnt = 0;
    int          timeout_limit = 0;

    bpu_top u_bpu_top (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .call_push_i  (call_push),
        .ret_addr_i   (ret_addr),
        .upd_valid_i  (upd_valid),
        .upd_i        (upd),
        .pred_o       (pred)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped by cycle limit");
        end
    end

    function automatic xlen_t rand_pc();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[31:2], 2'b00};   // word aligned
    endfunction

    function automatic bpu_update_t mk_upd(xlen_t pc, inst_t inst, xlen_t target, logic taken);
        bpu_update_t u;
        u.pc     = pc;
        u.inst   = inst;
        u.target = target;
        u.taken  = taken;
        return u;
    endfunction

    function automatic bpu_pred_t exp_pred(logic is_ctrl, logic taken, xlen_t target);
        bpu_pred_t p;
        p.is_ctrl = is_ctrl;
        p.taken   = taken;
        p.target  = target;
        return p;
    endfunction

    task automatic add_row(input string name, input logic push, input xlen_t ra,
                           input logic uv, input bpu_update_t u, input xlen_t pc,
                           input inst_t inst, input bpu_pred_t exp);
        row_t r;
        r = '{call_push: push, ret_addr: ra, upd_valid: uv, upd: u,
              fetch_pc: pc, fetch_inst: inst, exp: exp};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_bit(input string name, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0b, actual %0b", name, field, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic check_addr(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("ERR %s target: expected %h, actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic drive_row(input row_t r);
        call_push  <= r.call_push;
        ret_addr   <= r.ret_addr;
        upd_valid  <= r.upd_valid;
        upd        <= r.upd;
        fetch_pc   <= r.fetch_pc;
        fetch_inst <= r.fetch_inst;
    endtask

    // each row's fetch sees the updates of the rows before it
    task automatic build_table();
        xlen_t pc_r;
        add_row("reset_branch", 0, '0, 0, NO_UPD, BR_PC, I_BEQ, exp_pred(1, 0, BR_PC + 4));
        pc_r = rand_pc();
        add_row("reset_nop", 0, '0, 0, NO_UPD, pc_r, I_NOP, exp_pred(0, 0, pc_r + 4));
        pc_r = rand_pc();
        add_row("train_taken_1", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_TGT, 1),
                pc_r, I_NOP, exp_pred(0, 0, pc_r + 4));
        add_row("train_taken_2", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_TGT, 1),
                BR_PC, I_BEQ, exp_pred(1, 1, BR_TGT));
        add_row("taken_after_two", 0, '0, 0, NO_UPD, BR_PC, I_BEQ, exp_pred(1, 1, BR_TGT));
        pc_r = rand_pc();
        add_row("train_taken_3", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_TGT, 1),
                pc_r, I_NOP, exp_pred(0, 0, pc_r + 4));
        add_row("train_not_taken_1", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_PC + 4, 0),
                BR_PC, I_BEQ, exp_pred(1, 1, BR_TGT));
        add_row("taken_at_two", 0, '0, 0, NO_UPD, BR_PC, I_BEQ, exp_pred(1, 1, BR_TGT));
        add_row("train_not_taken_2", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_PC + 4, 0),
                BR_PC, I_BEQ, exp_pred(1, 1, BR_TGT));
        add_row("train_not_taken_3", 0, '0, 1, mk_upd(BR_PC, I_BEQ, BR_PC + 4, 0),
                BR_PC, I_BEQ, exp_pred(1, 0, BR_PC + 4));
        add_row("not_taken_at_zero", 0, '0, 0, NO_UPD, BR_PC, I_BEQ,
                exp_pred(1, 0, BR_PC + 4));
        // jal falls back to the decoded offset until the btb holds it
        add_row("jal_btb_miss", 0, '0, 1, mk_upd(JAL_PC, I_JAL, JAL_TGT, 1),
                JAL_PC, I_JAL, exp_pred(1, 1, JAL_PC + JAL_OFF));
        add_row("jal_btb_hit", 0, '0, 0, NO_UPD, JAL_PC, I_JAL, exp_pred(1, 1, JAL_TGT));
        add_row("jal_tag_mismatch", 0, '0, 0, NO_UPD, JAL_ALIAS, I_JAL,
                exp_pred(1, 1, JAL_ALIAS + JAL_OFF));
        add_row("ret_empty_push_a", 1, RA_A, 0, NO_UPD, RET_PC, I_RET,
                exp_pred(1, 0, RET_PC + 4));
        pc_r = rand_pc();
        add_row("push_b", 1, RA_B, 0, NO_UPD, pc_r, I_NOP, exp_pred(0, 0, pc_r + 4));
        add_row("ret_top_b", 0, '0, 1, mk_upd(RET_PC, I_RET, RA_B, 1),
                RET_PC, I_RET, exp_pred(1, 1, RA_B));
        add_row("ret_top_a", 0, '0, 1, mk_upd(RET_PC, I_RET, RA_A, 1),
                RET_PC, I_RET, exp_pred(1, 1, RA_A));
        // pop request on an empty stack
        add_row("ret_after_pops", 0, '0, 1, mk_upd(RET_PC, I_RET, RA_A, 1),
                RET_PC, I_RET, exp_pred(1, 0, RET_PC + 4));
        pc_r = rand_pc();
        add_row("refill_a", 1, RA_A, 0, NO_UPD, pc_r, I_NOP, exp_pred(0, 0, pc_r + 4));
        add_row("refill_b", 1, RA_B, 0, NO_UPD, RET_PC, I_RET, exp_pred(1, 1, RA_A));
        add_row("pop_push_c", 1, RA_C, 1, mk_upd(RET_PC, I_RET, RA_B, 1),
                RET_PC, I_RET, exp_pred(1, 1, RA_B));
        add_row("ret_top_c", 0, '0, 1, mk_upd(RET_PC, I_RET, RA_C, 1),
                RET_PC, I_RET, exp_pred(1, 1, RA_C));
        add_row("ret_under_c", 0, '0, 1, mk_upd(RET_PC, I_RET, RA_A, 1),
                RET_PC, I_RET, exp_pred(1, 1, RA_A));
        add_row("ret_empty_again", 0, '0, 0, NO_UPD, RET_PC, I_RET,
                exp_pred(1, 0, RET_PC + 4));
        add_row("jalr_other", 0, '0, 0, NO_UPD, JALR_PC, I_JALR, exp_pred(1, 0, JALR_PC + 4));
    endtask

    initial begin
        rst        = 1'b1;
        fetch_pc   = '0;
        fetch_inst = I_NOP;
        call_push  = 1'b0;
        ret_addr   = '0;
        upd_valid  = 1'b0;
        upd        = NO_UPD;
        build_table();
        timeout_limit = 16 + 2 * rows.size() + 20;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            @(negedge clk);   // combinational prediction has settled
            check_bit(names[i], "is_ctrl", rows[i].exp.is_ctrl, pred.is_ctrl);
            check_bit(names[i], "taken", rows[i].exp.taken, pred.taken);
            check_addr(names[i], rows[i].exp.target, pred.target);
        end

        @(posedge clk);
        drive_row('0);
        @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- bpu_top.sv
module bpu_top
    import rv_inst_pkg::*, bpu_cfg_pkg::*;
#(
    parameter int BHT_INDEX_W = 9,
    parameter int BTB_INDEX_W = 8,
    parameter int RAS_DEPTH   = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  xlen_t       fetch_pc_i,
    input  inst_t       fetch_inst_i,
    input  logic        call_push_i,
    input  xlen_t       ret_addr_i,
    input  logic        upd_valid_i,
    input  bpu_update_t upd_i,
    output bpu_pred_t   pred_o
);

    decoded_inst_t fetch_dec;
    decoded_inst_t exec_dec;
    ctr_t          bht_ctr;
    logic          btb_hit;
    xlen_t         btb_target;
    logic          ras_empty;
    xlen_t         ras_top;
    logic          upd_taken;
    logic          ras_pop;

    assign upd_taken = upd_valid_i && upd_i.taken;
    assign ras_pop   = upd_taken && (exec_dec.cls == CLS_RET);   // retired return

    branch_decode u_fetch_dec (
        .inst_i (fetch_inst_i),
        .dec_o  (fetch_dec)
    );

    // execute side only needs the class
    branch_decode u_exec_dec (
        .inst_i (upd_i.inst),
        .dec_o  (exec_dec)
    );

    bimodal_table #(.BHT_INDEX_W(BHT_INDEX_W)) u_bht (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (fetch_pc_i),
        .rd_ctr_o    (bht_ctr),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_i.pc),
        .upd_taken_i (upd_i.taken)
    );

    branch_target_buffer #(.BTB_INDEX_W(BTB_INDEX_W)) u_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (fetch_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_i        (upd_taken),
        .wr_pc_i     (upd_i.pc),
        .wr_target_i (upd_i.target)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (call_push_i),
        .push_addr_i (ret_addr_i),
        .pop_i       (ras_pop),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    next_pc_select u_sel (
        .pc_i         (fetch_pc_i),
        .dec_i        (fetch_dec),
        .ctr_i        (bht_ctr),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_empty_i  (ras_empty),
        .ras_top_i    (ras_top),
        .pred_o       (pred_o)
    );

endmodule

//--- next_pc_select.sv
module next_pc_select
    import rv_inst_pkg::*, bpu_cfg_pkg::*;
(
    input  xlen_t         pc_i,
    input  decoded_inst_t dec_i,
    input  ctr_t          ctr_i,
    input  logic          btb_hit_i,
    input  xlen_t         btb_target_i,
    input  logic          ras_empty_i,
    input  xlen_t         ras_top_i,
    output bpu_pred_t     pred_o
);

    xlen_t pc_seq;
    xlen_t pc_jump;

    assign pc_seq  = pc_i + xlen_t'(4);
    // btb wins over the decoded offset
    assign pc_jump = btb_hit_i ? btb_target_i : pc_i + dec_i.offset;

    always_comb begin
        pred_o.is_ctrl = (dec_i.cls != CLS_NONE);
        pred_o.taken   = 1'b0;
        pred_o.target  = pc_seq;
        case (dec_i.cls)
            CLS_RET: begin
                if (!ras_empty_i) begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = ras_top_i;
                end
            end
            CLS_JAL: begin
                pred_o.taken  = 1'b1;     // unconditional
                pred_o.target = pc_jump;
            end
            CLS_BRANCH: begin
                if (ctr_i[1]) begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = pc_jump;
                end
            end
            default: ;   // plain jalr falls through
        endcase
    end

endmodule

//--- return_stack.sv
module return_stack
    import bpu_cfg_pkg::*;
#(
    parameter int RAS_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  xlen_t push_addr_i,
    input  logic  pop_i,
    output logic  empty_o,
    output xlen_t top_o
);

    // pointer must reach RAS_DEPTH itself when full
    localparam int PTR_W = $clog2(RAS_DEPTH + 1);
    localparam int IDX_W = $clog2(RAS_DEPTH);

    typedef logic [PTR_W-1:0] ras_ptr_t;
    typedef logic [IDX_W-1:0] ras_idx_t;

    xlen_t    stack_q [RAS_DEPTH];
    ras_ptr_t sp_q;          // next free slot
    ras_ptr_t sp_pop;        // pointer after the pop
    ras_idx_t top_idx;
    logic     pop_ok;
    logic     push_ok;

    assign empty_o = (sp_q == '0);
    assign top_idx = empty_o ? '0 : ras_idx_t'(sp_q - ras_ptr_t'(1));
    assign top_o   = stack_q[top_idx];

    // pop first, then push lands on the freed slot
    assign pop_ok  = pop_i && !empty_o;     // underflow dropped
    assign sp_pop  = sp_q - ras_ptr_t'(pop_ok);
    assign push_ok = push_i && (sp_pop < ras_ptr_t'(RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_pop + ras_ptr_t'(push_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_q[ras_idx_t'(sp_pop)] <= push_addr_i;
        end
    end

    a_sp_in_range: assert property (
        @(posedge clk) disable iff (rst)
        sp_q <= ras_ptr_t'(RAS_DEPTH)
    ) else $error("return stack pointer out of range");

endmodule

//--- branch_target_buffer.sv
module branch_target_buffer
    import bpu_cfg_pkg::*;
#(
    parameter int BTB_INDEX_W = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  xlen_t rd_pc_i,
    output logic  hit_o,
    output xlen_t target_o,
    input  logic  wr_i,
    input  xlen_t wr_pc_i,
    input  xlen_t wr_target_i
);

    localparam int ENTRIES = 2 ** BTB_INDEX_W;
    localparam int TAG_W   = $bits(xlen_t) - BTB_INDEX_W - 2;

    typedef logic [BTB_INDEX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0]       btb_tag_t;

    logic     valid_q  [ENTRIES];
    btb_tag_t tag_q    [ENTRIES];
    xlen_t    target_q [ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;

    // word index, tag is everything above it
    assign rd_idx = rd_pc_i[BTB_INDEX_W+1:2];
    assign rd_tag = rd_pc_i[$bits(xlen_t)-1:BTB_INDEX_W+2];
    assign wr_idx = wr_pc_i[BTB_INDEX_W+1:2];
    assign wr_tag = wr_pc_i[$bits(xlen_t)-1:BTB_INDEX_W+2];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target payload of each entry
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q[wr_idx]    <= wr_tag;    // direct mapped, always replace
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

//--- bimodal_table.sv
module bimodal_table
    import bpu_cfg_pkg::*;
#(
    parameter int BHT_INDEX_W = 9
) (
    input  logic  clk,
    input  logic  rst,
    input  xlen_t rd_pc_i,
    output ctr_t  rd_ctr_o,
    input  logic  upd_valid_i,
    input  xlen_t upd_pc_i,
    input  logic  upd_taken_i
);

    localparam int ENTRIES = 2 ** BHT_INDEX_W;

    typedef logic [BHT_INDEX_W-1:0] bht_idx_t;

    ctr_t     ctr_q [ENTRIES];
    bht_idx_t rd_idx;
    bht_idx_t wr_idx;
    ctr_t     cur_ctr;
    ctr_t     nxt_ctr;

    // halfword granular index, skips bit 0
    assign rd_idx = rd_pc_i[BHT_INDEX_W:1];
    assign wr_idx = upd_pc_i[BHT_INDEX_W:1];

    assign rd_ctr_o = ctr_q[rd_idx];
    assign cur_ctr  = ctr_q[wr_idx];

    always_comb begin
        nxt_ctr = cur_ctr;
        if (upd_taken_i) begin
            if (cur_ctr != 2'b11) nxt_ctr = cur_ctr + 2'b01;   // saturate at strongly taken
        end else begin
            if (cur_ctr != 2'b00) nxt_ctr = cur_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_valid_i) begin
            ctr_q[wr_idx] <= nxt_ctr;
        end
    end

    // execute must resolve the direction before it strobes
    a_upd_taken_known: assert property (
        @(posedge clk) disable iff (rst)
        upd_valid_i |-> !$isunknown(upd_taken_i)
    ) else $error("bimodal update with unknown taken bit");

endmodule

//--- branch_decode.sv
module branch_decode
    import rv_inst_pkg::*, bpu_cfg_pkg::*;
(
    input  inst_t         inst_i,
    output decoded_inst_t dec_o
);

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    logic     is_ret;
    xlen_t    b_off;
    xlen_t    j_off;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    // jalr x0, 0(ra) or jalr x0, 0(t0)
    assign is_ret = (rd == REG_ZERO) &&
                    ((rs1 == REG_RA) || (rs1 == REG_T0)) &&
                    (inst_i[31:20] == 12'h000);

    // B-type immediate
    assign b_off = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    // J-type immediate
    assign j_off = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        dec_o.cls    = CLS_NONE;
        dec_o.offset = '0;
        case (opcode)
            OPC_BRANCH: begin
                dec_o.cls    = CLS_BRANCH;
                dec_o.offset = b_off;
            end
            OPC_JAL: begin
                dec_o.cls    = CLS_JAL;
                dec_o.offset = j_off;
            end
            OPC_JALR: begin
                dec_o.cls = is_ret ? CLS_RET : CLS_JALR;   // target is register based
            end
            default: ;
        endcase
    end

endmodule

//--- bpu_cfg_pkg.sv
package bpu_cfg_pkg;

    typedef logic [31:0] xlen_t;    // pc or target address
    typedef logic [1:0]  ctr_t;     // saturating counter, msb = taken

    // weakly not-taken
    localparam ctr_t CTR_RESET = 2'b01;

    typedef struct packed {
        logic  is_ctrl;
        logic  taken;
        xlen_t target;
    } bpu_pred_t;

    // resolved control instruction from execute
    typedef struct packed {
        xlen_t              pc;
        rv_inst_pkg::inst_t inst;
        xlen_t              target;
        logic               taken;
    } bpu_update_t;

endpackage

//--- rv_inst_pkg.sv
package rv_inst_pkg;

    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [31:0] imm_t;      // sign-extended immediate, pc wide
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;

    // control-transfer major opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd1;   // x1, standard link register
    localparam reg_idx_t REG_T0   = 5'd5;   // x5, alternate link register

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_RET
    } inst_class_e;

    typedef struct packed {
        inst_class_e cls;
        imm_t        offset;    // B or J immediate, zero otherwise
    } decoded_inst_t;

endpackage
